/* source/pw_pkg.sv */
package pw_pkg;

   localparam int PATTERN_BYTES_DEF = 4;
   localparam int FIFO_DEPTH_DEF    = 16;
   localparam int TS_WIDTH          = 8;
   localparam int REC_WIDTH         = 18;   // {cmd, timestamp, payload}
   localparam int DELAY_WIDTH       = 16;
   localparam int PULSE_WIDTH       = 16;
   localparam int CAP_LEN_WIDTH     = 12;

   typedef enum logic [1:0] {
      CMD_DATA  = 2'b00,
      CMD_START = 2'b01,
      CMD_END   = 2'b10
   } fe_cmd_e;

   typedef enum logic [1:0] {
      TRIG_IDLE  = 2'b00,
      TRIG_DELAY = 2'b01,
      TRIG_PULSE = 2'b10,
      TRIG_DONE  = 2'b11
   } trig_state_e;

   typedef enum logic {CAP_IDLE = 1'b0, CAP_RUN = 1'b1} cap_state_e;

endpackage

/* source/fe_rx_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_rx_frontend (
   input  wire        fe_clk,
   input  wire        rst_i,
   input  wire  [7:0] fe_data_i,
   input  wire        fe_rxvalid_i,
   input  wire        fe_rxactive_i,
   output logic       pkt_start_o,
   output logic       byte_stb_o,
   output logic [7:0] byte_data_o,
   output logic [7:0] byte_idx_o,
   output logic       pkt_end_o
);

   logic       rxactive_q;
   logic [7:0] byte_cnt_q;
   logic       rx_rise;
   logic       rx_fall;
   logic       rx_byte;
   logic [7:0] idx_base;

   assign rx_rise  = fe_rxactive_i & ~rxactive_q;
   assign rx_fall  = ~fe_rxactive_i & rxactive_q;
   assign rx_byte  = fe_rxvalid_i & fe_rxactive_i;
   assign idx_base = rx_rise ? 8'd0 : byte_cnt_q;   // new packet restarts the index

   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         rxactive_q  <= 1'b0;
         byte_cnt_q  <= '0;
         pkt_start_o <= 1'b0;
         byte_stb_o  <= 1'b0;
         byte_idx_o  <= '0;
         pkt_end_o   <= 1'b0;
      end else begin
         rxactive_q  <= fe_rxactive_i;
         pkt_start_o <= rx_rise;
         pkt_end_o   <= rx_fall;
         byte_stb_o  <= rx_byte;
         byte_cnt_q  <= idx_base;
         if (rx_byte) begin
            byte_idx_o <= idx_base;
            if (idx_base != 8'hff) begin   // saturate on very long packets
               byte_cnt_q <= idx_base + 8'd1;
            end
         end
      end
   end

   always_ff @(posedge fe_clk) begin
      if (rx_byte) begin
         byte_data_o <= fe_data_i;
      end
   end

endmodule
`default_nettype wire

/* source/pattern_matcher.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_matcher import pw_pkg::*; #(
   parameter int PATTERN_BYTES = PATTERN_BYTES_DEF
) (
   input  wire                       fe_clk,
   input  wire                       rst_i,
   input  wire [PATTERN_BYTES*8-1:0] pattern_i,
   input  wire [PATTERN_BYTES*8-1:0] mask_i,
   input  wire                       byte_stb_i,
   input  wire                 [7:0] byte_data_i,
   input  wire                 [7:0] byte_idx_i,
   input  wire                       pkt_start_i,
   input  wire                       enable_i,
   output logic                      match_o
);

   localparam int SEL_W = (PATTERN_BYTES > 1) ? $clog2(PATTERN_BYTES) : 1;

   logic [SEL_W-1:0] sel;
   logic       [7:0] pat_byte;
   logic       [7:0] mask_byte;
   logic             in_window;
   logic             last_byte;
   logic             byte_ok;
   logic             ok_base;
   logic             all_ok_q;   // every leading byte so far matched

   assign sel       = byte_idx_i[SEL_W-1:0];
   assign pat_byte  = pattern_i[sel*8 +: 8];   // byte 0 sits in bits 7:0
   assign mask_byte = mask_i[sel*8 +: 8];
   assign in_window = (32'(byte_idx_i) < PATTERN_BYTES);
   assign last_byte = (32'(byte_idx_i) == PATTERN_BYTES - 1);
   // only bits set in the mask take part
   assign byte_ok   = (((byte_data_i ^ pat_byte) & mask_byte) == 8'h00);
   assign ok_base   = pkt_start_i | all_ok_q;

   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         all_ok_q <= 1'b0;
         match_o  <= 1'b0;
      end else begin
         match_o <= 1'b0;
         if (byte_stb_i && in_window) begin
            all_ok_q <= ok_base & byte_ok & enable_i;
            if (last_byte) begin
               match_o <= ok_base & byte_ok & enable_i;
            end
         end else if (pkt_start_i) begin
            all_ok_q <= 1'b1;
         end
      end
   end

endmodule
`default_nettype wire

/* source/trigger_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module trigger_gen import pw_pkg::*; (
   input  wire                   fe_clk,
   input  wire                   rst_i,
   input  wire                   arm_i,
   input  wire                   match_i,
   input  wire [DELAY_WIDTH-1:0] delay_i,
   input  wire [PULSE_WIDTH-1:0] width_i,
   output logic                  trig_o,
   output logic                  fired_o
);

   localparam int CNT_W = (DELAY_WIDTH > PULSE_WIDTH) ? DELAY_WIDTH : PULSE_WIDTH;

   trig_state_e      state_q;
   logic [CNT_W-1:0] cnt_q;   // shared by delay and pulse phases

   assign fired_o = (state_q != TRIG_IDLE);

   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         state_q <= TRIG_IDLE;
         cnt_q   <= '0;
         trig_o  <= 1'b0;
      end else begin
         case (state_q)
            TRIG_IDLE: begin
               if (match_i) begin
                  state_q <= TRIG_DELAY;
                  cnt_q   <= CNT_W'(delay_i);
               end
            end
            TRIG_DELAY: begin
               if (cnt_q == '0) begin
                  state_q <= TRIG_PULSE;
                  cnt_q   <= CNT_W'(width_i - PULSE_WIDTH'(1));
                  trig_o  <= 1'b1;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            TRIG_PULSE: begin
               if (cnt_q == '0) begin
                  state_q <= TRIG_DONE;
                  trig_o  <= 1'b0;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            default: begin   // TRIG_DONE waits for re-arm
               if (arm_i) begin
                  state_q <= TRIG_IDLE;
               end
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // checks

   a_width_nonzero: assert property (@(posedge fe_clk) disable iff (rst_i)
      (match_i && state_q == TRIG_IDLE) |-> (width_i != '0));

   a_trig_in_pulse: assert property (@(posedge fe_clk) disable iff (rst_i)
      trig_o |-> (state_q == TRIG_PULSE));

endmodule
`default_nettype wire

/* source/capture_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_ctrl import pw_pkg::*; (
   input  wire                     fe_clk,
   input  wire                     rst_i,
   input  wire                     arm_i,
   input  wire [CAP_LEN_WIDTH-1:0] capture_len_i,
   input  wire                     pkt_start_i,
   input  wire                     byte_stb_i,
   input  wire               [7:0] byte_data_i,
   input  wire               [7:0] byte_idx_i,
   input  wire                     pkt_end_i,
   input  wire                     fifo_full_i,
   output logic                    capturing_o,
   output logic                    overflow_o,
   output logic                    rec_push_o,
   output logic    [REC_WIDTH-1:0] rec_word_o
);

   cap_state_e               state_q;
   logic [CAP_LEN_WIDTH-1:0] rec_cnt_q;     // records accepted by the FIFO
   logic      [TS_WIDTH-1:0] ts_q;          // cycles since last record
   logic               [7:0] pkt_bytes_q;
   logic                     written;
   logic                     last_write;
   logic                     event_seen;
   fe_cmd_e                  cmd;
   logic               [7:0] payload;

   assign written     = rec_push_o & ~fifo_full_i;
   assign last_write  = written && (rec_cnt_q + 1'b1 == capture_len_i);
   assign event_seen  = pkt_start_i | byte_stb_i | pkt_end_i;
   assign capturing_o = (state_q == CAP_RUN);

   // start wins; utmi raises rxvalid only after the first rxactive cycle
   always_comb begin
      if (pkt_start_i) begin
         cmd     = CMD_START;
         payload = 8'h00;
      end else if (pkt_end_i) begin
         cmd     = CMD_END;
         payload = pkt_bytes_q;
      end else begin
         cmd     = CMD_DATA;
         payload = byte_data_i;
      end
   end

   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         state_q    <= CAP_IDLE;
         rec_cnt_q  <= '0;
         ts_q       <= '0;
         overflow_o <= 1'b0;
         rec_push_o <= 1'b0;
      end else begin
         rec_push_o <= 1'b0;
         if (ts_q != '1) ts_q <= ts_q + 1'b1;   // saturating
         if (written) rec_cnt_q <= rec_cnt_q + 1'b1;
         if (rec_push_o && fifo_full_i) overflow_o <= 1'b1;   // sticky
         if (arm_i) begin
            state_q    <= CAP_RUN;
            rec_cnt_q  <= '0;
            overflow_o <= 1'b0;
            ts_q       <= TS_WIDTH'(1);
         end else if (state_q == CAP_RUN) begin
            if (last_write) begin
               state_q <= CAP_IDLE;   // no new record on the closing edge
            end else if (event_seen) begin
               rec_push_o <= 1'b1;
               ts_q       <= TS_WIDTH'(1);
            end
         end
      end
   end

   always_ff @(posedge fe_clk) begin
      if (pkt_start_i) begin
         pkt_bytes_q <= '0;
      end else if (byte_stb_i) begin
         pkt_bytes_q <= (byte_idx_i == 8'hff) ? 8'hff : byte_idx_i + 8'd1;
      end
      if (event_seen) begin
         rec_word_o <= {cmd, ts_q, payload};
      end
   end

   a_no_push_idle: assert property (@(posedge fe_clk) disable iff (rst_i)
      rec_push_o |-> (state_q == CAP_RUN));

endmodule
`default_nettype wire

/* source/capture_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_fifo import pw_pkg::*; #(
   parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
   input  wire                  fe_clk,
   input  wire                  rst_i,
   input  wire                  push_i,
   input  wire  [REC_WIDTH-1:0] push_data_i,
   input  wire                  rec_ready_i,
   output logic                 full_o,
   output logic                 rec_valid_o,
   output logic [REC_WIDTH-1:0] rec_data_o
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [REC_WIDTH-1:0] mem_q [FIFO_DEPTH];
   logic     [PTR_W-1:0] wr_ptr_q;
   logic     [PTR_W-1:0] rd_ptr_q;
   logic     [CNT_W-1:0] count_q;
   logic                 do_push;
   logic                 do_pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full_o      = (count_q == CNT_W'(FIFO_DEPTH));
   assign rec_valid_o = (count_q != '0);
   assign rec_data_o  = mem_q[rd_ptr_q];   // held until popped
   assign do_push     = push_i & ~full_o;  // push on full is dropped
   assign do_pop      = rec_valid_o & rec_ready_i;

   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge fe_clk) begin
      if (do_push) mem_q[wr_ptr_q] <= push_data_i;
   end

   a_count_bound: assert property (@(posedge fe_clk) disable iff (rst_i)
      count_q <= CNT_W'(FIFO_DEPTH));

endmodule
`default_nettype wire

/* source/phywhisperer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module phywhisperer_top import pw_pkg::*; #(
   parameter int PATTERN_BYTES = PATTERN_BYTES_DEF,
   parameter int FIFO_DEPTH    = FIFO_DEPTH_DEF
) (
   input  wire                       fe_clk,
   input  wire                       rst_i,
   input  wire                 [7:0] fe_data_i,
   input  wire                       fe_rxvalid_i,
   input  wire                       fe_rxactive_i,
   input  wire                       arm_i,
   input  wire [PATTERN_BYTES*8-1:0] pattern_i,
   input  wire [PATTERN_BYTES*8-1:0] mask_i,
   input  wire     [DELAY_WIDTH-1:0] delay_i,
   input  wire     [PULSE_WIDTH-1:0] width_i,
   input  wire   [CAP_LEN_WIDTH-1:0] capture_len_i,
   input  wire                       rec_ready_i,
   output logic                      trig_o,
   output logic                      capturing_o,
   output logic                      overflow_o,
   output logic                      rec_valid_o,
   output logic      [REC_WIDTH-1:0] rec_data_o
);

   //////////////////////////////////////////////////
   // stage-to-stage strobes

   logic                 pkt_start;
   logic                 byte_stb;
   logic           [7:0] byte_data;
   logic           [7:0] byte_idx;
   logic                 pkt_end;
   logic                 match;
   logic                 fired;
   logic                 rec_push;
   logic [REC_WIDTH-1:0] rec_word;
   logic                 fifo_full;

   fe_rx_frontend u_fe_rx_frontend (
      .fe_clk        (fe_clk),
      .rst_i         (rst_i),
      .fe_data_i     (fe_data_i),
      .fe_rxvalid_i  (fe_rxvalid_i),
      .fe_rxactive_i (fe_rxactive_i),
      .pkt_start_o   (pkt_start),
      .byte_stb_o    (byte_stb),
      .byte_data_o   (byte_data),
      .byte_idx_o    (byte_idx),
      .pkt_end_o     (pkt_end)
   );

   pattern_matcher #(
      .PATTERN_BYTES (PATTERN_BYTES)
   ) u_pattern_matcher (
      .fe_clk        (fe_clk),
      .rst_i         (rst_i),
      .pattern_i     (pattern_i),
      .mask_i        (mask_i),
      .byte_stb_i    (byte_stb),
      .byte_data_i   (byte_data),
      .byte_idx_i    (byte_idx),
      .pkt_start_i   (pkt_start),
      .enable_i      (capturing_o & ~fired),   // one trigger per arm
      .match_o       (match)
   );

   trigger_gen u_trigger_gen (
      .fe_clk        (fe_clk),
      .rst_i         (rst_i),
      .arm_i         (arm_i),
      .match_i       (match),
      .delay_i       (delay_i),
      .width_i       (width_i),
      .trig_o        (trig_o),
      .fired_o       (fired)
   );

   capture_ctrl u_capture_ctrl (
      .fe_clk        (fe_clk),
      .rst_i         (rst_i),
      .arm_i         (arm_i),
      .capture_len_i (capture_len_i),
      .pkt_start_i   (pkt_start),
      .byte_stb_i    (byte_stb),
      .byte_data_i   (byte_data),
      .byte_idx_i    (byte_idx),
      .pkt_end_i     (pkt_end),
      .fifo_full_i   (fifo_full),
      .capturing_o   (capturing_o),
      .overflow_o    (overflow_o),
      .rec_push_o    (rec_push),
      .rec_word_o    (rec_word)
   );

   capture_fifo #(
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) u_capture_fifo (
      .fe_clk        (fe_clk),
      .rst_i         (rst_i),
      .push_i        (rec_push),
      .push_data_i   (rec_word),
      .rec_ready_i   (rec_ready_i),
      .full_o        (fifo_full),
      .rec_valid_o   (rec_valid_o),
      .rec_data_o    (rec_data_o)
   );

endmodule
`default_nettype wire

/* verif/tb_tasks.svh */
// report a mismatch between a DUT value and the expected one
task automatic check_value(input string name, input logic [31:0] got_v,
                           input logic [31:0] exp_v);
   if (got_v !== exp_v) begin
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got_v, exp_v);
      err_cnt++;
      test_err++;
   end
endtask

task automatic log_event(input fe_cmd_e cmd, input logic [7:0] pay);
   ev_cmd.push_back(cmd);
   ev_cyc.push_back(cyc + 1);   // edge that samples this input
   ev_pay.push_back(pay);
endtask

// one UTMI packet with rxactive leading the first byte by a cycle
task automatic drive_packet(input int t);
   int len;
   int gap;
   len = int'(tv[t][C_LEN]);
   gap = int'(tv[t][C_GAP]);
   @(negedge fe_clk);
   fe_rxactive_i = 1'b1;
   log_event(CMD_START, 8'h00);
   for (int i = 0; i < len; i++) begin
      @(negedge fe_clk);
      fe_rxvalid_i = 1'b1;
      fe_data_i    = tv[t][C_B0 + i][7:0];
      log_event(CMD_DATA, fe_data_i);
      if (i == PATTERN_BYTES_DEF - 1 && last_pat_cyc < 0) last_pat_cyc = cyc + 1;
      repeat (gap - 1) begin
         @(negedge fe_clk);
         fe_rxvalid_i = 1'b0;
      end
   end
   @(negedge fe_clk);
   fe_rxvalid_i  = 1'b0;
   fe_rxactive_i = 1'b0;
   log_event(CMD_END, 8'(len));
   repeat (4) @(negedge fe_clk);   // let the end record reach the FIFO
endtask

// drain records with ready high (mode 0), randomly stalled (1) or held low (2)
task automatic drain_records(input int mode);
   logic [REC_WIDTH-1:0] held;
   bit                   stalled;
   int                   rnd;
   stalled = 1'b0;
   held    = '0;
   while (!(pkt_done && !rec_valid_o)) begin
      @(negedge fe_clk);
      rnd = $random(seed);
      if (pkt_done || mode == 0) rec_ready_i = 1'b1;
      else if (mode == 1) rec_ready_i = rnd[0];
      else rec_ready_i = 1'b0;
      if (rec_valid_o) begin
         if (stalled) check_value("rec_data_o", 32'(rec_data_o), 32'(held));
         if (rec_ready_i) got.push_back(rec_data_o);   // moves on the next rising edge
         held    = rec_data_o;
         stalled = !rec_ready_i;
      end else begin
         stalled = 1'b0;
      end
   end
   rec_ready_i = 1'b1;
endtask

/* verif/tb_top.sv */
`timescale 1ns/1ps

module tb_top import pw_pkg::*; ();

   // golden file columns
   localparam int C_PAT   = 0;
   localparam int C_MASK  = 1;
   localparam int C_DLY   = 2;
   localparam int C_WID   = 3;
   localparam int C_CAP   = 4;
   localparam int C_STALL = 5;
   localparam int C_NPKT  = 6;
   localparam int C_LEN   = 7;
   localparam int C_B0    = 8;
   localparam int C_GAP   = 16;
   localparam int C_TRIG  = 17;
   localparam int C_RECS  = 18;
   localparam int C_OVF   = 19;
   localparam int N_COL   = 20;

   logic                       fe_clk;
   logic                       rst_i;
   logic                 [7:0] fe_data_i;
   logic                       fe_rxvalid_i;
   logic                       fe_rxactive_i;
   logic                       arm_i;
   logic [PATTERN_BYTES_DEF*8-1:0] pattern_i;
   logic [PATTERN_BYTES_DEF*8-1:0] mask_i;
   logic     [DELAY_WIDTH-1:0] delay_i;
   logic     [PULSE_WIDTH-1:0] width_i;
   logic   [CAP_LEN_WIDTH-1:0] capture_len_i;
   logic                       rec_ready_i;
   logic                       trig_o;
   logic                       capturing_o;
   logic                       overflow_o;
   logic                       rec_valid_o;
   logic       [REC_WIDTH-1:0] rec_data_o;

   logic [31:0] tv [16][N_COL];
   int          n_tests;
   int          cyc;
   int          err_cnt;
   int          test_err;
   int          n_bad;
   int          arm_cyc;
   int          last_pat_cyc;
   int          pulse_cnt;
   int          rise_cyc;
   int          high_cnt;
   int          limit;
   integer      seed;
   bit          trig_prev;
   bit          pkt_done;
   bit          loaded;
   fe_cmd_e              ev_cmd [$];
   int                   ev_cyc [$];
   logic           [7:0] ev_pay [$];
   logic [REC_WIDTH-1:0] got [$];

   `include "tb_tasks.svh"

   phywhisperer_top #(
      .PATTERN_BYTES (PATTERN_BYTES_DEF),
      .FIFO_DEPTH    (FIFO_DEPTH_DEF)
   ) u_phywhisperer_top (
      .fe_clk        (fe_clk),
      .rst_i         (rst_i),
      .fe_data_i     (fe_data_i),
      .fe_rxvalid_i  (fe_rxvalid_i),
      .fe_rxactive_i (fe_rxactive_i),
      .arm_i         (arm_i),
      .pattern_i     (pattern_i),
      .mask_i        (mask_i),
      .delay_i       (delay_i),
      .width_i       (width_i),
      .capture_len_i (capture_len_i),
      .rec_ready_i   (rec_ready_i),
      .trig_o        (trig_o),
      .capturing_o   (capturing_o),
      .overflow_o    (overflow_o),
      .rec_valid_o   (rec_valid_o),
      .rec_data_o    (rec_data_o)
   );

   initial begin
      fe_clk = 1'b0;
      forever #50 fe_clk = ~fe_clk;
   end

   initial cyc = 0;
   always @(posedge fe_clk) cyc <= cyc + 1;

   //////////////////////////////////////////////////
   // trigger monitor sampled mid-cycle

   always @(negedge fe_clk) begin
      if (trig_o) begin
         if (!trig_prev) begin
            pulse_cnt++;
            if (rise_cyc < 0) rise_cyc = cyc;
         end
         high_cnt++;
      end
      trig_prev = trig_o;
   end

   initial begin
      wait (loaded);
      #(limit * 100);
      $display("watchdog expired after %0d cycles", limit);
      $display("Test failed");
      $finish;
   end

   task automatic run_test(input int t);
      int n;
      int ts;
      int bound;
      int mode;
      logic [REC_WIDTH-1:0] exp_word;
      test_err      = 0;
      mode          = int'(tv[t][C_STALL]);
      pattern_i     = tv[t][C_PAT];
      mask_i        = tv[t][C_MASK];
      delay_i       = tv[t][C_DLY][15:0];
      width_i       = tv[t][C_WID][15:0];
      capture_len_i = tv[t][C_CAP][11:0];
      ev_cmd.delete();
      ev_cyc.delete();
      ev_pay.delete();
      got.delete();
      pulse_cnt    = 0;
      high_cnt     = 0;
      rise_cyc     = -1;
      last_pat_cyc = -1;
      @(negedge fe_clk);
      arm_i   = 1'b1;
      arm_cyc = cyc + 1;
      @(negedge fe_clk);
      arm_i = 1'b0;
      check_value("overflow_o", 32'(overflow_o), 32'h0);   // arm clears it
      pkt_done = 1'b0;
      fork
         begin
            for (int p = 0; p < int'(tv[t][C_NPKT]); p++) drive_packet(t);
            pkt_done = 1'b1;
         end
         drain_records(mode);
      join
      bound = (last_pat_cyc >= 0) ? last_pat_cyc : cyc;
      bound = bound + int'(delay_i) + int'(width_i) + 4;
      while (cyc < bound) @(negedge fe_clk);

      // records the DUT should have written
      n = ev_cmd.size();
      if (n > int'(capture_len_i)) n = int'(capture_len_i);
      if (mode == 2 && n > FIFO_DEPTH_DEF) n = FIFO_DEPTH_DEF;
      check_value("record count", 32'(got.size()), tv[t][C_RECS]);
      check_value("model record count", 32'(n), tv[t][C_RECS]);
      for (int i = 0; i < n && i < got.size(); i++) begin
         ts = (i == 0) ? ev_cyc[0] - arm_cyc + 1 : ev_cyc[i] - ev_cyc[i-1];
         if (ts > 255) ts = 255;
         exp_word = {ev_cmd[i], ts[7:0], ev_pay[i]};
         check_value("rec_data_o", 32'(got[i]), 32'(exp_word));
      end
      check_value("trig_o pulses", 32'(pulse_cnt), tv[t][C_TRIG]);
      if (tv[t][C_TRIG] != 0) begin
         check_value("trig_o rise cycle", 32'(rise_cyc),
                     32'(last_pat_cyc + int'(delay_i) + 3));
         check_value("trig_o width", 32'(high_cnt), 32'(width_i));
      end
      check_value("overflow_o", 32'(overflow_o), tv[t][C_OVF]);
      check_value("capturing_o", 32'(capturing_o), 32'(n < int'(capture_len_i)));
      if (test_err != 0) n_bad++;
      $display("test %0d: %s, %0d records", t, (test_err == 0) ? "ok" : "bad", got.size());
   endtask

   initial begin
      int    fd;
      int    cnt;
      string line;
      fe_data_i = 8'h00;
      fe_rxvalid_i = 1'b0;
      fe_rxactive_i = 1'b0;
      arm_i = 1'b0;
      pattern_i = '0;
      mask_i = '0;
      delay_i = '0;
      width_i = 16'd1;
      capture_len_i = '0;
      rec_ready_i = 1'b1;
      rst_i = 1'b1;
      seed = 32'h583696ce;
      err_cnt = 0;
      n_bad = 0;
      n_tests = 0;
      limit = 200;
      trig_prev = 1'b0;
      loaded = 1'b0;
      fd = $fopen("verif/pw_golden.txt", "r");
      if (fd == 0) begin
         $display("cannot open the golden file verif/pw_golden.txt");
         $display("Test failed");
         $finish;
      end else begin
         while ($fgets(line, fd) != 0 && n_tests < 16) begin
            if (line.len() > 4 && line[0] != "#") begin
               cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  tv[n_tests][0], tv[n_tests][1], tv[n_tests][2], tv[n_tests][3],
                  tv[n_tests][4], tv[n_tests][5], tv[n_tests][6], tv[n_tests][7],
                  tv[n_tests][8], tv[n_tests][9], tv[n_tests][10], tv[n_tests][11],
                  tv[n_tests][12], tv[n_tests][13], tv[n_tests][14], tv[n_tests][15],
                  tv[n_tests][16], tv[n_tests][17], tv[n_tests][18], tv[n_tests][19]);
               if (cnt != N_COL) begin
                  $display("golden file line has %0d fields instead of %0d", cnt, N_COL);
                  err_cnt++;
               end else begin
                  // packets, byte gaps, trigger time and per-test overhead
                  limit += int'(tv[n_tests][C_NPKT])
                           * (int'(tv[n_tests][C_LEN]) * int'(tv[n_tests][C_GAP]) + 8);
                  limit += int'(tv[n_tests][C_DLY]) + int'(tv[n_tests][C_WID]) + 40;
                  n_tests++;
               end
            end
         end
         $fclose(fd);
         loaded = 1'b1;
         repeat (10) @(negedge fe_clk);
         rst_i = 1'b0;
         for (int t = 0; t < n_tests; t++) run_test(t);
         $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                  n_tests, n_tests - n_bad, n_bad, err_cnt);
         if (err_cnt == 0 && n_tests > 0) begin
            $display("Test passed");
         end else begin
            $display("Test failed");
         end
         $finish;
      end
   end

endmodule

/* verif/pw_golden.txt */
# all columns hex: pattern mask delay width caplen stall(0 rdy,1 rand,2 low) npkt len
# bytes b0..b7, gap, expected trigger pulses, expected records, expected overflow
d2001069 ffffffff 2 3 ff 0 1 6 69 10 00 d2 aa 55 00 00 1 1 8 0
d2001069 f0ff00ff 0 1 ff 0 1 4 69 77 00 d5 00 00 00 00 2 1 6 0
d2001069 f0ff00ff 0 1 ff 0 1 5 69 77 01 d5 33 00 00 00 1 0 7 0
d2001069 ffffffff 1 4 ff 0 2 4 69 10 00 d2 00 00 00 00 1 1 c 0
d2001069 ffffffff 10 2 5 0 1 6 69 10 00 d2 aa 55 00 00 1 1 5 0
00000000 00000000 5 5 ff 1 1 8 01 02 03 04 05 06 07 08 3 1 a 0
00000000 00000000 0 2 ff 2 2 8 11 22 33 44 55 66 77 88 1 1 10 1
00000000 00000000 0 1 ff 0 1 2 5a a5 00 00 00 00 00 00 12c 0 4 0

/* build.f */
+incdir+verif
source/pw_pkg.sv
source/fe_rx_frontend.sv
source/pattern_matcher.sv
source/trigger_gen.sv
source/capture_ctrl.sv
source/capture_fifo.sv
source/phywhisperer_top.sv
verif/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, then scan the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f build.f --top-module tb_top -o tb_top_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/tb_top_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

if grep -q "^Test failed$" sim.log || ! grep -q "^Test passed$" sim.log; then
   exit 1
fi
exit 0
